/* run_sim.sh */
#!/bin/sh
# Build and run the USB link simulation with Verilator.
# A failing check ends the run with $fatal, which gives a non-zero exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module usb_link_tb -f verilog.f \
  --Mdir obj_dir -o usb_link_sim

./obj_dir/usb_link_sim

/* src/usb_bus_pins.sv */
/*
 * USB bus pin model
 * Maps host line symbols to dp/dn, swaps pins when the device pull-up
 * sits on dn, and forces SE0 while no pull-up is attached. The
 * differential receive bit keeps its last valid value through SE0.
 */
`timescale 1ns/1ps

module usb_bus_pins (
  input  logic                      clk_48MHz_i,
  input  logic                      reset,
  input  usb_link_pkg::host_drive_t host,
  input  logic                      pullup_dp,
  input  logic                      pullup_dn,
  output usb_link_pkg::line_t       line
);

  logic                    attached;
  logic                    flip;
  usb_link_pkg::line_sym_e sym;
  logic                    dp;
  logic                    dn;
  logic                    d_hold;

  assign attached = pullup_dp || pullup_dn;
  // Pull-up on dn means the device has its pins swapped
  assign flip = pullup_dn;

  always_comb begin
    // Undriven bus rests at J through the pull-up
    sym = host.drive ? host.sym : usb_link_pkg::sym_j;
    case (sym)
      usb_link_pkg::sym_k: begin
        dp = flip;
        dn = ~flip;
      end
      usb_link_pkg::sym_se0: begin
        dp = 1'b0;
        dn = 1'b0;
      end
      default: begin
        dp = ~flip;
        dn = flip;
      end
    endcase
    if (!attached) begin
      dp = 1'b0;
      dn = 1'b0;
    end
  end

  always_ff @(posedge clk_48MHz_i) begin
    if (reset || !attached) begin
      d_hold <= 1'b0;
    end else begin
      d_hold <= line.d;
    end
  end

  assign line.dp = dp;
  assign line.dn = dn;
  assign line.se0 = !dp && !dn;
  assign line.d = (dp && !dn) ? 1'b1 : (!dp && dn) ? 1'b0 : d_hold;

endmodule

/* src/usb_device_rx.sv */
/*
 * USB device receiver
 * Recovers the bit phase from edges of the differential bit, finds SYNC,
 * NRZI-decodes, drops stuffed bits and pushes assembled bytes. The byte
 * before EOP is pushed with its last flag set.
 */
`timescale 1ns/1ps

module usb_device_rx (
  input  logic                     clk_48MHz_i,
  input  logic                     reset,
  input  usb_link_pkg::line_t      line,
  output logic                     push,
  output usb_link_pkg::byte_item_t push_item
);

  usb_link_pkg::rx_state_e state;
  usb_link_pkg::phase_t    phase;
  usb_link_pkg::ones_t     ones;
  logic                    d_q;
  logic                    last_sample;
  logic                    sample;
  logic                    bit_val;
  logic                    sync_done;
  logic [2:0]              sync_cnt;
  logic [2:0]              bit_cnt;
  logic [7:0]              shift;
  logic [7:0]              pending;
  logic                    pend_valid;

  // Mid-bit sample, two cycles after the last edge
  assign sample = phase == usb_link_pkg::phase_t'(1) && line.d == d_q && !line.se0;
  // NRZI: no change since the previous sample is a one
  assign bit_val = line.d == last_sample;
  assign sync_done = sync_cnt == 3'(usb_link_pkg::sync_zeros - 1);

  always_ff @(posedge clk_48MHz_i) begin
    if (reset) begin
      d_q   <= 1'b0;
      phase <= '0;
    end else begin
      d_q <= line.d;
      if (line.d != d_q) begin
        phase <= '0;
      end else if (phase == usb_link_pkg::phase_t'(usb_link_pkg::clks_per_bit - 1)) begin
        phase <= '0;
      end else begin
        phase <= phase + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_48MHz_i) begin
    if (reset) begin
      state       <= usb_link_pkg::rx_idle;
      push        <= 1'b0;
      pend_valid  <= 1'b0;
      last_sample <= 1'b0;
      sync_cnt    <= '0;
      bit_cnt     <= '0;
      ones        <= '0;
    end else begin
      push <= 1'b0;
      if (line.se0) begin
        // EOP closes the packet and flags the held byte
        if (state == usb_link_pkg::rx_data && pend_valid) begin
          push           <= 1'b1;
          push_item.data <= pending;
          push_item.last <= 1'b1;
        end
        pend_valid <= 1'b0;
        state      <= usb_link_pkg::rx_idle;
      end else if (sample) begin
        last_sample <= line.d;
        case (state)
          usb_link_pkg::rx_idle: begin
            if (!bit_val) begin
              state    <= usb_link_pkg::rx_sync;
              sync_cnt <= '0;
            end
          end
          usb_link_pkg::rx_sync: begin
            if (!bit_val) begin
              // Extra leading zeros are tolerated
              if (!sync_done) begin
                sync_cnt <= sync_cnt + 3'd1;
              end
            end else if (sync_done) begin
              state      <= usb_link_pkg::rx_data;
              ones       <= usb_link_pkg::ones_t'(1);
              bit_cnt    <= '0;
              pend_valid <= 1'b0;
            end else begin
              state <= usb_link_pkg::rx_idle;
            end
          end
          default: begin
            if (ones == usb_link_pkg::ones_t'(usb_link_pkg::stuff_run)) begin
              ones <= '0;
            end else begin
              ones    <= bit_val ? ones + 1'b1 : '0;
              shift   <= {bit_val, shift[7:1]};
              bit_cnt <= bit_cnt + 3'd1;
              if (pend_valid) begin
                push           <= 1'b1;
                push_item.data <= pending;
                push_item.last <= 1'b0;
                pend_valid     <= 1'b0;
              end
              if (bit_cnt == 3'd7) begin
                pending    <= {bit_val, shift[7:1]};
                pend_valid <= 1'b1;
              end
            end
          end
        endcase
      end else if (state == usb_link_pkg::rx_idle && line.d != d_q) begin
        // Idle level just before the first edge of a packet
        last_sample <= d_q;
      end
    end
  end

  // Byte pushes are at least one bit time apart
  assert property (@(posedge clk_48MHz_i) disable iff (reset) push |=> !push);

endmodule

/* src/usb_host_tx.sv */
/*
 * USB host bit transmitter
 * Takes bytes over a four-phase handshake and sends them as one packet:
 * SYNC, NRZI data LSB first with bit stuffing, then SE0 SE0 J.
 */
`timescale 1ns/1ps

module usb_host_tx (
  input  logic                     clk_48MHz_i,
  input  logic                     reset,
  input  logic                     in_req,
  input  usb_link_pkg::byte_item_t in_item,
  output logic                     in_ack,
  output usb_link_pkg::host_drive_t host
);

  usb_link_pkg::tx_state_e  state;
  usb_link_pkg::byte_item_t cur;
  usb_link_pkg::byte_item_t nxt;
  logic                     nxt_valid;
  usb_link_pkg::phase_t     phase;
  usb_link_pkg::ones_t      ones;
  logic [2:0]               bit_idx;
  logic [1:0]               eop_cnt;
  logic                     stuffing;
  // NRZI line level, 1 is J
  logic                     level;
  logic                     bit_end;
  logic                     need_stuff;
  logic                     byte_slot;
  logic                     take;
  logic                     byte_end;
  logic                     packet_done;
  logic                     next_bit;

  assign bit_end = phase == usb_link_pkg::phase_t'(usb_link_pkg::clks_per_bit - 1);
  assign need_stuff = ones == usb_link_pkg::ones_t'(usb_link_pkg::stuff_run);

  // Lookahead byte is only taken during the last data bit of a byte
  assign byte_slot = (state == usb_link_pkg::tx_idle) ||
                     (state == usb_link_pkg::tx_data && bit_idx == 3'd7 && !stuffing &&
                      !nxt_valid && !cur.last);
  assign take = in_req && !in_ack && byte_slot;

  assign byte_end = bit_end && !need_stuff && state == usb_link_pkg::tx_data &&
                    bit_idx == 3'd7;
  assign packet_done = cur.last || !(nxt_valid || take);

  // Value of the bit that follows the current one
  always_comb begin
    next_bit = 1'b0;
    case (state)
      usb_link_pkg::tx_sync: next_bit = (bit_idx == 3'd7) ? cur.data[0] : (bit_idx == 3'd6);
      usb_link_pkg::tx_data: begin
        if (bit_idx != 3'd7) begin
          next_bit = cur.data[bit_idx + 3'd1];
        end else begin
          next_bit = nxt_valid ? nxt.data[0] : in_item.data[0];
        end
      end
      default: next_bit = 1'b0;
    endcase
  end

  always_ff @(posedge clk_48MHz_i) begin
    if (reset) begin
      state     <= usb_link_pkg::tx_idle;
      in_ack    <= 1'b0;
      nxt_valid <= 1'b0;
      phase     <= '0;
      ones      <= '0;
      bit_idx   <= '0;
      eop_cnt   <= '0;
      stuffing  <= 1'b0;
      level     <= 1'b1;
    end else begin
      if (!in_req) begin
        in_ack <= 1'b0;
      end else if (take) begin
        in_ack <= 1'b1;
      end
      if (take && state == usb_link_pkg::tx_data && !byte_end) begin
        nxt       <= in_item;
        nxt_valid <= 1'b1;
      end
      if (state != usb_link_pkg::tx_idle) begin
        phase <= bit_end ? '0 : phase + 1'b1;
      end
      case (state)
        usb_link_pkg::tx_idle: begin
          if (take) begin
            cur      <= in_item;
            state    <= usb_link_pkg::tx_sync;
            phase    <= '0;
            bit_idx  <= '0;
            ones     <= '0;
            stuffing <= 1'b0;
            // First SYNC bit is a zero, so the line moves to K
            level    <= 1'b0;
          end
        end
        usb_link_pkg::tx_sync, usb_link_pkg::tx_data: begin
          if (bit_end && need_stuff) begin
            stuffing <= 1'b1;
            ones     <= '0;
            level    <= ~level;
          end else if (bit_end) begin
            stuffing <= 1'b0;
            ones     <= next_bit ? ones + 1'b1 : '0;
            level    <= next_bit ? level : ~level;
            bit_idx  <= bit_idx + 3'd1;
            if (state == usb_link_pkg::tx_sync && bit_idx == 3'd7) begin
              state <= usb_link_pkg::tx_data;
            end else if (byte_end && packet_done) begin
              state   <= usb_link_pkg::tx_eop;
              eop_cnt <= '0;
              ones    <= '0;
              level   <= 1'b1;
            end else if (byte_end) begin
              cur       <= nxt_valid ? nxt : in_item;
              nxt_valid <= 1'b0;
            end
          end
        end
        default: begin
          if (bit_end) begin
            if (eop_cnt == 2'd2) begin
              state <= usb_link_pkg::tx_idle;
            end else begin
              eop_cnt <= eop_cnt + 2'd1;
            end
          end
        end
      endcase
    end
  end

  assign host.drive = state != usb_link_pkg::tx_idle;
  assign host.sym = (state == usb_link_pkg::tx_eop && eop_cnt != 2'd2) ? usb_link_pkg::sym_se0 :
                    level ? usb_link_pkg::sym_j : usb_link_pkg::sym_k;

  // Handshake order: ack only answers a request already seen
  assert property (@(posedge clk_48MHz_i) disable iff (reset)
    $rose(in_ack) |-> $past(in_req));

endmodule

/* src/usb_link_pkg.sv */
/*
 * USB full-speed link package
 * Bus timing constants, line symbols and the structs passed between
 * the host transmitter, pin model, device receiver and receive FIFO.
 */
package usb_link_pkg;

  // Full-speed bit time in 48 MHz clocks
  localparam int clks_per_bit = 4;
  // Consecutive ones before a stuffed zero
  localparam int stuff_run = 6;
  localparam int fifo_depth = 8;
  // Zeros at the start of SYNC before the closing one
  localparam int sync_zeros = 7;

  localparam int phase_w = $clog2(clks_per_bit);
  localparam int ones_w = $clog2(stuff_run + 1);
  localparam int fifo_ptr_w = $clog2(fifo_depth);
  localparam int fifo_cnt_w = $clog2(fifo_depth + 1);

  typedef logic [phase_w-1:0] phase_t;
  typedef logic [ones_w-1:0] ones_t;
  typedef logic [fifo_ptr_w-1:0] ptr_t;
  typedef logic [fifo_cnt_w-1:0] cnt_t;

  typedef enum logic [1:0] {
    sym_j   = 2'd0,
    sym_k   = 2'd1,
    sym_se0 = 2'd2
  } line_sym_e;

  typedef struct packed {
    line_sym_e sym;
    logic      drive;
  } host_drive_t;

  typedef struct packed {
    logic dp;
    logic dn;
    logic d;
    logic se0;
  } line_t;

  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } byte_item_t;

  typedef enum logic [1:0] {
    tx_idle,
    tx_sync,
    tx_data,
    tx_eop
  } tx_state_e;

  typedef enum logic [1:0] {
    rx_idle,
    rx_sync,
    rx_data
  } rx_state_e;

endpackage

/* src/usb_link_top.sv */
/*
 * USB full-speed link top level
 * Host transmitter drives the bus pins, the device receiver decodes
 * the line and fills the receive FIFO.
 */
`timescale 1ns/1ps

module usb_link_top (
  input  logic                     clk_48MHz_i,
  input  logic                     reset,
  input  logic                     in_req,
  input  usb_link_pkg::byte_item_t in_item,
  output logic                     in_ack,
  input  logic                     pullup_dp,
  input  logic                     pullup_dn,
  output logic                     dp,
  output logic                     dn,
  output logic                     out_req,
  output usb_link_pkg::byte_item_t out_item,
  input  logic                     out_ack,
  output logic                     overflow
);

  usb_link_pkg::host_drive_t host;
  usb_link_pkg::line_t       line;
  logic                      push;
  usb_link_pkg::byte_item_t  push_item;

  usb_host_tx usb_host_tx_i (
    .clk_48MHz_i (clk_48MHz_i),
    .reset       (reset),
    .in_req      (in_req),
    .in_item     (in_item),
    .in_ack      (in_ack),
    .host        (host)
  );

  usb_bus_pins usb_bus_pins_i (
    .clk_48MHz_i (clk_48MHz_i),
    .reset       (reset),
    .host        (host),
    .pullup_dp   (pullup_dp),
    .pullup_dn   (pullup_dn),
    .line        (line)
  );

  assign dp = line.dp;
  assign dn = line.dn;

  usb_device_rx usb_device_rx_i (
    .clk_48MHz_i (clk_48MHz_i),
    .reset       (reset),
    .line        (line),
    .push        (push),
    .push_item   (push_item)
  );

  usb_rx_fifo usb_rx_fifo_i (
    .clk_48MHz_i (clk_48MHz_i),
    .reset       (reset),
    .push        (push),
    .push_item   (push_item),
    .out_req     (out_req),
    .out_item    (out_item),
    .out_ack     (out_ack),
    .overflow    (overflow)
  );

endmodule

/* src/usb_rx_fifo.sv */
/*
 * Receive byte FIFO
 * Circular buffer between the receiver and a four-phase output port.
 * Pushes into a full buffer are dropped and set a sticky overflow flag.
 */
`timescale 1ns/1ps

module usb_rx_fifo (
  input  logic                     clk_48MHz_i,
  input  logic                     reset,
  input  logic                     push,
  input  usb_link_pkg::byte_item_t push_item,
  output logic                     out_req,
  output usb_link_pkg::byte_item_t out_item,
  input  logic                     out_ack,
  output logic                     overflow
);

  usb_link_pkg::byte_item_t mem [usb_link_pkg::fifo_depth];
  usb_link_pkg::ptr_t       wr_ptr;
  usb_link_pkg::ptr_t       rd_ptr;
  usb_link_pkg::cnt_t       count;
  logic                     full;
  logic                     push_ok;
  logic                     ack_q;
  logic                     pop;

  assign full = count == usb_link_pkg::cnt_t'(usb_link_pkg::fifo_depth);
  assign push_ok = push && !full;
  assign pop = out_ack && !ack_q;

  always_ff @(posedge clk_48MHz_i) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_item;
    end
  end

  always_ff @(posedge clk_48MHz_i) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      out_req  <= 1'b0;
      ack_q    <= 1'b0;
      overflow <= 1'b0;
    end else begin
      ack_q <= out_ack;
      if (push_ok) begin
        wr_ptr <= (wr_ptr == usb_link_pkg::ptr_t'(usb_link_pkg::fifo_depth - 1)) ?
                  '0 : wr_ptr + 1'b1;
      end
      if (push && full) begin
        overflow <= 1'b1;
      end
      // Offer the head entry once the previous ack has dropped
      if (!out_req && !out_ack && count != '0) begin
        out_req  <= 1'b1;
        out_item <= mem[rd_ptr];
      end else if (pop && out_req) begin
        out_req <= 1'b0;
        rd_ptr  <= (rd_ptr == usb_link_pkg::ptr_t'(usb_link_pkg::fifo_depth - 1)) ?
                   '0 : rd_ptr + 1'b1;
      end
      count <= count + usb_link_pkg::cnt_t'(push_ok) -
               usb_link_pkg::cnt_t'(pop && out_req);
    end
  end

  assert property (@(posedge clk_48MHz_i) disable iff (reset)
    out_req |=> !out_req || $stable(out_item));

endmodule

/* testbench/usb_link_tb.sv */
/*
 * USB link testbench
 * Sends table-driven packets through the host transmitter and checks
 * the bytes, last flags, pin levels and overflow seen at the FIFO port.
 */
`timescale 1ns/1ps

module usb_link_tb;

  localparam int mode_ff = 0;
  localparam int mode_00 = 1;
  localparam int mode_rand = 2;
  localparam int n_cases = 7;

  typedef struct packed {
    logic       pu_dp;
    logic       pu_dn;
    logic [4:0] len;
    logic [1:0] mode;
    logic       hold_ack;
  } case_t;

  logic                     clk_48MHz_i;
  logic                     reset;
  logic                     in_req;
  usb_link_pkg::byte_item_t in_item;
  logic                     in_ack;
  logic                     pullup_dp;
  logic                     pullup_dn;
  logic                     dp;
  logic                     dn;
  logic                     out_req;
  usb_link_pkg::byte_item_t out_item;
  logic                     out_ack;
  logic                     overflow;

  case_t                    cases [n_cases];
  usb_link_pkg::byte_item_t sent_q [$];
  usb_link_pkg::byte_item_t exp_q [$];
  logic [31:0]              lcg_state;
  int                       cycles;
  int                       limit;

  usb_link_top usb_link_top_i (
    .clk_48MHz_i (clk_48MHz_i),
    .reset       (reset),
    .in_req      (in_req),
    .in_item     (in_item),
    .in_ack      (in_ack),
    .pullup_dp   (pullup_dp),
    .pullup_dn   (pullup_dn),
    .dp          (dp),
    .dn          (dn),
    .out_req     (out_req),
    .out_item    (out_item),
    .out_ack     (out_ack),
    .overflow    (overflow)
  );

  initial begin
    clk_48MHz_i = 1'b0;
    forever #2 clk_48MHz_i = ~clk_48MHz_i;
  end

  function automatic logic [7:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  // SYNC, data and EOP bits of every packet in the table
  function automatic int table_bits();
    int total;
    total = 0;
    for (int i = 0; i < n_cases; i++) begin
      total += 11 + 8 * int'(cases[i].len);
    end
    return total;
  endfunction

  task automatic fill_table();
    // pullup_dp, pullup_dn, length, data mode, hold out_ack
    cases[0] = '{1'b1, 1'b0, 5'd1, 2'(mode_rand), 1'b0};
    cases[1] = '{1'b1, 1'b0, 5'd5, 2'(mode_ff), 1'b0};
    cases[2] = '{1'b0, 1'b1, 5'd3, 2'(mode_rand), 1'b0};
    cases[3] = '{1'b0, 1'b1, 5'd6, 2'(mode_rand), 1'b0};
    cases[4] = '{1'b0, 1'b0, 5'd2, 2'(mode_00), 1'b0};
    cases[5] = '{1'b1, 1'b0, 5'd12, 2'(mode_rand), 1'b1};
    cases[6] = '{1'b1, 1'b0, 5'd2, 2'(mode_00), 1'b0};
  endtask

  // Inputs change and outputs are read 1 ns after the rising edge
  task automatic step();
    @(posedge clk_48MHz_i);
    #1;
  endtask

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string msg);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s, got %0h, expected %0h", $time, msg, actual, expected);
      $display("TESTS FAILED");
      $fatal(1, "check failed");
    end
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    in_req = 1'b0;
    out_ack = 1'b0;
    repeat (3) step();
    reset = 1'b0;
  endtask

  task automatic send_packet();
    foreach (sent_q[i]) begin
      in_item = sent_q[i];
      in_req = 1'b1;
      while (!in_ack) step();
      in_req = 1'b0;
      while (in_ack) step();
    end
  endtask

  // EOP seen on the pins, then the bus leaves SE0
  task automatic wait_packet_end();
    while (dp || dn) step();
    while (!dp && !dn) step();
  endtask

  task automatic read_packet(input case_t c);
    int window;
    if (!(c.pu_dp || c.pu_dn)) begin
      window = (int'(c.len) * 10 + 11) * usb_link_pkg::clks_per_bit + 100;
      repeat (window) begin
        step();
        check(32'(dp), 32'd0, "dp without pull-up");
        check(32'(dn), 32'd0, "dn without pull-up");
        check(32'(out_req), 32'd0, "out_req without pull-up");
      end
    end else begin
      if (c.hold_ack) begin
        wait_packet_end();
      end
      foreach (exp_q[i]) begin
        while (!out_req) step();
        check(32'(out_item), 32'(exp_q[i]), "received byte and last flag");
        out_ack = 1'b1;
        while (out_req) step();
        out_ack = 1'b0;
      end
    end
  endtask

  task automatic run_case(input int idx);
    case_t                    c;
    logic                     attached;
    usb_link_pkg::byte_item_t item;
    c = cases[idx];
    attached = c.pu_dp || c.pu_dn;
    pullup_dp = c.pu_dp;
    pullup_dn = c.pu_dn;
    apply_reset();
    // Idle bus is J, which lands on dn when the pins are swapped
    check(32'(dp), 32'(attached && !c.pu_dn), "idle dp");
    check(32'(dn), 32'(attached && c.pu_dn), "idle dn");
    check(32'(overflow), 32'd0, "overflow after reset");
    check(32'(out_req), 32'd0, "out_req after reset");
    check(32'(in_ack), 32'd0, "in_ack after reset");
    sent_q.delete();
    exp_q.delete();
    for (int i = 0; i < int'(c.len); i++) begin
      case (int'(c.mode))
        mode_ff: item.data = 8'hFF;
        mode_00: item.data = 8'h00;
        default: item.data = lcg_next();
      endcase
      item.last = (i == int'(c.len) - 1);
      sent_q.push_back(item);
    end
    // A held-back reader keeps only what fits in the FIFO
    if (attached) begin
      foreach (sent_q[i]) begin
        if (!c.hold_ack || i < usb_link_pkg::fifo_depth) begin
          exp_q.push_back(sent_q[i]);
        end
      end
    end
    fork
      send_packet();
      read_packet(c);
    join
    check(32'(overflow), 32'(c.hold_ack && int'(c.len) > usb_link_pkg::fifo_depth),
          "overflow flag");
    check(32'(out_req), 32'd0, "out_req after last byte");
  endtask

  initial begin
    cycles = 0;
    @(posedge clk_48MHz_i);
    limit = table_bits() * usb_link_pkg::clks_per_bit * 2 + 1000;
    forever begin
      @(posedge clk_48MHz_i);
      cycles++;
      if (cycles > limit) begin
        $display("TESTS FAILED");
        $fatal(1, "timeout, run did not finish within %0d cycles", limit);
      end
    end
  end

  initial begin
    reset = 1'b1;
    in_req = 1'b0;
    in_item = '0;
    out_ack = 1'b0;
    pullup_dp = 1'b0;
    pullup_dn = 1'b0;
    lcg_state = 32'd66373;
    fill_table();
    for (int i = 0; i < n_cases; i++) begin
      run_case(i);
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* verilog.f */
src/usb_link_pkg.sv
src/usb_host_tx.sv
src/usb_bus_pins.sv
src/usb_device_rx.sv
src/usb_rx_fifo.sv
src/usb_link_top.sv
testbench/usb_link_tb.sv
